/* verilog/ubaPkg.sv */
// Bus-side interrupt types shared by the adapter and its devices
package ubaPkg;

   // PI level, 0 is off and 1..7 are live levels
   typedef logic [2:0] piLevelT;

   // Unibus request lines BR7..BR4
   typedef logic [7:4] brReqT;

   // One-hot PI request bus toward the CPU, element n is level n
   typedef logic [1:7] busIntrT;

   // Device grant, one-hot BR7..BR4 or all zero
   typedef logic [7:4] intaT;

   // WRU answer word in PDP-10 order, bit 0 is the MSB
   typedef logic [0:35] wruWordT;

   ////////////////////////////////////////
   // Grant codes
   ////////////////////////////////////////

   // Nobody granted
   localparam intaT intaNone = 4'b0000;

   // High group grants
   localparam intaT intaBr7  = 4'b1000;
   localparam intaT intaBr6  = 4'b0100;

   // Low group grants
   localparam intaT intaBr5  = 4'b0010;
   localparam intaT intaBr4  = 4'b0001;

endpackage

/* verilog/ubaCsrPkg.sv */
// Status register layout and the structs that carry its contents
package ubaCsrPkg;

   // PI assignment pair, high level serves BR7/BR6, low level BR5/BR4
   typedef struct packed {
      ubaPkg::piLevelT pih;
      ubaPkg::piLevelT pil;
   } piPairT;

   // CPU write strobe with the written half-word
   typedef struct packed {
      logic        wr;
      logic        init;
      logic [17:0] data;
   } csrWriteT;

   ////////////////////////////////////////
   // Half-word field positions
   ////////////////////////////////////////

   // Level fields, pih sits above pil
   localparam int csrPihLsb  = 15;
   localparam int csrPilLsb  = 12;

   // Live summary bits, readback only
   localparam int csrIntHiBit = 11;
   localparam int csrIntLoBit = 10;

   // Initialize request inside the written half-word
   localparam int csrInitBit  = 6;

endpackage

/* verilog/ubaStatus.sv */
`timescale 1ns/1ps

// Adapter status register
module ubaStatus (
   input  logic                clk,
   input  logic                rst,
   input  ubaCsrPkg::csrWriteT csrWr,
   input  logic                intHi,
   input  logic                intLo,
   output ubaCsrPkg::piPairT   piLevels,
   output logic [17:0]         csrRead
);

   import ubaCsrPkg::*;

   ////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////

   // Init comes from its own strobe or from the
   // init bit of a normal write
   logic initReq;

   // Level fields pulled out of the half-word
   piPairT wrLevels;

   assign initReq = csrWr.init | (csrWr.wr & csrWr.data[csrInitBit]);

   always_comb
   begin
      wrLevels.pih = csrWr.data[csrPihLsb +: 3];
      wrLevels.pil = csrWr.data[csrPilLsb +: 3];
   end

   ////////////////////////////////////////
   // Level register
   ////////////////////////////////////////

   // Init wins over a plain write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         piLevels <= '0;
      end
      else if (initReq)
      begin
         // Both levels back to disabled
         piLevels <= '0;
      end
      else if (csrWr.wr)
      begin
         piLevels <= wrLevels;
      end
   end

   ////////////////////////////////////////
   // Readback
   ////////////////////////////////////////

   // Held levels plus the live summary bits,
   // everything else reads as zero
   always_comb
   begin
      csrRead                      = '0;
      csrRead[csrPihLsb +: 3]      = piLevels.pih;
      csrRead[csrPilLsb +: 3]      = piLevels.pil;

      // Summary bits come straight from the request OR
      csrRead[csrIntHiBit]         = intHi;
      csrRead[csrIntLoBit]         = intLo;
   end

endmodule

/* verilog/ubaIntr.sv */
`timescale 1ns/1ps

// Interrupt request mapping and WRU grant
module ubaIntr (
   input  logic              clk,
   input  logic              rst,
   input  logic              wruRead,
   input  ubaPkg::piLevelT   busPi,
   input  ubaPkg::brReqT     dev1Req,
   input  ubaPkg::brReqT     dev2Req,
   input  ubaCsrPkg::piPairT piLevels,
   output logic              intHi,
   output logic              intLo,
   output ubaPkg::busIntrT   busIntr,
   output ubaPkg::intaT      devInta,
   output logic              unitReq
);

   import ubaPkg::*;

   // Level to one-hot PI line
   // Level 0 selects nothing
   function automatic busIntrT piDecode(input piLevelT lvl);
      busIntrT lines;
      lines = '0;
      if (lvl != 3'd0)
      begin
         lines[lvl] = 1'b1;
      end
      return lines;
   endfunction

   ////////////////////////////////////////
   // Request summary
   ////////////////////////////////////////

   // Both device groups share the BR lines
   brReqT intReq;

   assign intReq = dev1Req | dev2Req;
   assign intHi  = intReq[7] | intReq[6];
   assign intLo  = intReq[5] | intReq[4];

   // Each active summary lights its own PI line
   assign busIntr = (intHi ? piDecode(piLevels.pih) : '0)
                  | (intLo ? piDecode(piLevels.pil) : '0);

   ////////////////////////////////////////
   // WRU level match
   ////////////////////////////////////////

   logic hiMatch;
   logic loMatch;
   intaT grant;

   // A disabled level never answers a WRU
   assign hiMatch = (busPi == piLevels.pih) && (piLevels.pih != 3'd0);
   assign loMatch = (busPi == piLevels.pil) && (piLevels.pil != 3'd0);

   // High level checked first, so equal levels favor BR7/BR6
   always_comb
   begin
      grant   = intaNone;
      unitReq = 1'b0;
      if (hiMatch)
      begin
         unitReq = intHi;
         if (intReq[7])
            grant = intaBr7;
         else if (intReq[6])
            grant = intaBr6;
      end
      else if (loMatch)
      begin
         unitReq = intLo;
         if (intReq[5])
            grant = intaBr5;
         else if (intReq[4])
            grant = intaBr4;
      end
   end

   // One-cycle grant per WRU strobe
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         devInta <= intaNone;
      else if (wruRead)
         devInta <= grant;
      else
         devInta <= intaNone;
   end

endmodule

/* verilog/ubaWru.sv */
`timescale 1ns/1ps

// Adapter answer to a WRU read
module ubaWru #(
   parameter int ubaNum = 1
) (
   input  logic            clk,
   input  logic            rst,
   input  logic            wruRead,
   input  logic            unitReq,
   output ubaPkg::wruWordT wruWord,
   output logic            wruValid
);

   import ubaPkg::*;

   ////////////////////////////////////////
   // Unit bit
   ////////////////////////////////////////

   // Unit n answers on right-half bit 18+n
   localparam int unitBit = 18 + ubaNum;

   logic    hit;
   wruWordT nextWord;

   // WRU at a level where this unit is asking
   assign hit = wruRead & unitReq;

   always_comb
   begin
      nextWord          = '0;
      nextWord[unitBit] = hit;
   end

   ////////////////////////////////////////
   // Response register
   ////////////////////////////////////////

   // One result cycle per strobe, word zero on a miss
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wruWord  <= '0;
         wruValid <= 1'b0;
      end
      else
      begin
         wruWord  <= nextWord;
         wruValid <= hit;
      end
   end

endmodule

/* verilog/ubaTop.sv */
`timescale 1ns/1ps

// Interrupt section of the Unibus adapter
module ubaTop #(
   parameter int ubaNum = 1
) (
   input  logic                clk,
   input  logic                rst,
   input  ubaCsrPkg::csrWriteT csrWr,
   output logic [17:0]         csrRead,
   input  logic                wruRead,
   input  ubaPkg::piLevelT     busPi,
   input  ubaPkg::brReqT       dev1Req,
   input  ubaPkg::brReqT       dev2Req,
   output ubaPkg::busIntrT     busIntr,
   output ubaPkg::intaT        devInta,
   output ubaPkg::wruWordT     wruWord,
   output logic                wruValid
);

   import ubaCsrPkg::*;

   // Levels out of the status register
   piPairT piLevels;

   // Summary bits back into the readback
   logic   intHi;
   logic   intLo;

   // This unit has a request at the WRU level
   logic   unitReq;

   ////////////////////////////////////////
   // Blocks
   ////////////////////////////////////////

   ubaStatus statusInst (
      .clk      (clk),
      .rst      (rst),
      .csrWr    (csrWr),
      .intHi    (intHi),
      .intLo    (intLo),
      .piLevels (piLevels),
      .csrRead  (csrRead)
   );

   ubaIntr intrInst (
      .clk      (clk),
      .rst      (rst),
      .wruRead  (wruRead),
      .busPi    (busPi),
      .dev1Req  (dev1Req),
      .dev2Req  (dev2Req),
      .piLevels (piLevels),
      .intHi    (intHi),
      .intLo    (intLo),
      .busIntr  (busIntr),
      .devInta  (devInta),
      .unitReq  (unitReq)
   );

   ubaWru #(
      .ubaNum (ubaNum)
   ) wruInst (
      .clk      (clk),
      .rst      (rst),
      .wruRead  (wruRead),
      .unitReq  (unitReq),
      .wruWord  (wruWord),
      .wruValid (wruValid)
   );

endmodule

/* bench/ubaChecker.sv */
`timescale 1ns/1ps

// Watches the adapter ports and scores them against a reference model
module ubaChecker #(
   parameter int ubaNum = 1
) (
   input  logic                clk,
   input  logic                rst,
   input  ubaCsrPkg::csrWriteT csrWr,
   input  logic [17:0]         csrRead,
   input  logic                wruRead,
   input  ubaPkg::piLevelT     busPi,
   input  ubaPkg::brReqT       dev1Req,
   input  ubaPkg::brReqT       dev2Req,
   input  ubaPkg::busIntrT     busIntr,
   input  ubaPkg::intaT        devInta,
   input  ubaPkg::wruWordT     wruWord,
   input  logic                wruValid,
   input  ubaPkg::intaT        tableInta,
   input  logic                tableCheck,
   output int                  checkCount,
   output int                  errCount
);

   import ubaPkg::*;
   import ubaCsrPkg::*;

   // Model copy of the two PI levels
   piLevelT mPih;
   piLevelT mPil;

   // Registered outputs expected at the next sample
   intaT    predInta;
   logic    predValid;
   intaT    predTable;
   logic    predTableOn;
   logic    cycleBad;

   task automatic compare(input string name, input logic [35:0] expv,
                          input logic [35:0] act);
      if (expv !== act)
      begin
         $display("Fail t=%0t %s expected %0h actual %0h", $time, name, expv, act);
         errCount++;
         cycleBad = 1'b1;
      end
   endtask

   ////////////////////////////////////////
   // Sample at the falling edge
   ////////////////////////////////////////

   always @(negedge clk)
   begin : sample
      brReqT       req;
      logic        hiReq;
      logic        loReq;
      busIntrT     expBus;
      logic [17:0] expRead;
      intaT        grant;
      logic        unitHit;
      wruWordT     expWord;
      if (rst)
      begin
         mPih        = '0;
         mPil        = '0;
         predInta    = intaNone;
         predValid   = 1'b0;
         predTableOn = 1'b0;
         checkCount  = 0;
         errCount    = 0;
      end
      else
      begin
         cycleBad = 1'b0;
         req      = dev1Req | dev2Req;
         hiReq    = req[7] | req[6];
         loReq    = req[5] | req[4];
         // A disabled level lights no PI line
         expBus = '0;
         if (hiReq && mPih != 3'd0)
            expBus[mPih] = 1'b1;
         if (loReq && mPil != 3'd0)
            expBus[mPil] = 1'b1;
         expRead                   = '0;
         expRead[csrPihLsb +: 3]   = mPih;
         expRead[csrPilLsb +: 3]   = mPil;
         expRead[csrIntHiBit]      = hiReq;
         expRead[csrIntLoBit]      = loReq;
         compare("busIntr", expBus, busIntr);
         compare("csrRead", expRead, csrRead);
         // Results of the strobe one edge back
         expWord               = '0;
         expWord[18 + ubaNum]  = predValid;
         compare("devInta", predInta, devInta);
         compare("wruValid", predValid, wruValid);
         compare("wruWord", expWord, wruWord);
         if (predTableOn)
            compare("devInta (table)", predTable, devInta);
         // High level matched first
         grant   = intaNone;
         unitHit = 1'b0;
         if (busPi == mPih && mPih != 3'd0)
         begin
            unitHit = hiReq;
            grant   = req[7] ? intaBr7 : (req[6] ? intaBr6 : intaNone);
         end
         else if (busPi == mPil && mPil != 3'd0)
         begin
            unitHit = loReq;
            grant   = req[5] ? intaBr5 : (req[4] ? intaBr4 : intaNone);
         end
         predInta    = wruRead ? grant : intaNone;
         predValid   = wruRead & unitHit;
         predTable   = tableInta;
         predTableOn = tableCheck;
         // Level write lands at the coming edge
         if (csrWr.init || (csrWr.wr && csrWr.data[csrInitBit]))
         begin
            mPih = '0;
            mPil = '0;
         end
         else if (csrWr.wr)
         begin
            mPih = csrWr.data[csrPihLsb +: 3];
            mPil = csrWr.data[csrPilLsb +: 3];
         end
         checkCount++;
         if (!cycleBad)
            $display("Cycle %0d ok", checkCount);
      end
   end

endmodule

/* bench/ubaBench.sv */
`timescale 1ns/1ps

// Testbench for the adapter interrupt section
module ubaBench;

   import ubaPkg::*;
   import ubaCsrPkg::*;

   // One clock cycle of stimulus
   // Op 0 idle, 1 levels, 2 init, 3 levels with init bit
   typedef struct packed {
      logic [1:0] op;
      piLevelT    pih;
      piLevelT    pil;
      brReqT      dev1;
      brReqT      dev2;
      logic       wru;
      piLevelT    pi;
      logic       hasExp;
      intaT       expInta;
   } rowT;

   logic        clk;
   logic        rst;
   csrWriteT    csrWr;
   logic [17:0] csrRead;
   logic        wruRead;
   piLevelT     busPi;
   brReqT       dev1Req;
   brReqT       dev2Req;
   busIntrT     busIntr;
   intaT        devInta;
   wruWordT     wruWord;
   logic        wruValid;
   intaT        tableInta;
   logic        tableCheck;
   int          checkCount;
   int          errCount;

   rowT         rows[$];
   logic [31:0] lfsr;
   logic        timedOut;
   int          waitCnt;
   int          target;

   ////////////////////////////////////////
   // Clock, DUT and checker
   ////////////////////////////////////////

   initial
      clk = 1'b0;
   always #4 clk = ~clk;

   ubaTop #(.ubaNum(3)) dut0 (
      .clk(clk), .rst(rst), .csrWr(csrWr), .csrRead(csrRead),
      .wruRead(wruRead), .busPi(busPi), .dev1Req(dev1Req), .dev2Req(dev2Req),
      .busIntr(busIntr), .devInta(devInta), .wruWord(wruWord), .wruValid(wruValid)
   );

   ubaChecker #(.ubaNum(3)) checker0 (
      .clk(clk), .rst(rst), .csrWr(csrWr), .csrRead(csrRead),
      .wruRead(wruRead), .busPi(busPi), .dev1Req(dev1Req), .dev2Req(dev2Req),
      .busIntr(busIntr), .devInta(devInta), .wruWord(wruWord), .wruValid(wruValid),
      .tableInta(tableInta), .tableCheck(tableCheck),
      .checkCount(checkCount), .errCount(errCount)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic takeBits(input int n, output logic [7:0] val);
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsrStep(lfsr);
         val  = {val[6:0], lfsr[0]};
      end
   endtask

   task automatic addRow(input logic [1:0] op, input piLevelT pih, input piLevelT pil,
                         input brReqT d1, input brReqT d2, input logic wru,
                         input piLevelT pi, input intaT expInta);
      rows.push_back({op, pih, pil, d1, d2, wru, pi, 1'b1, expInta});
   endtask

   // Random row with a level write about one time in four
   task automatic addRandom();
      rowT        r;
      logic [7:0] v;
      r = '0;
      takeBits(2, v);
      r.op = (v[1:0] == 2'd0) ? 2'd1 : 2'd0;
      takeBits(3, v);
      r.pih = v[2:0];
      takeBits(3, v);
      r.pil = v[2:0];
      takeBits(4, v);
      r.dev1 = v[3:0];
      takeBits(4, v);
      r.dev2 = v[3:0];
      takeBits(1, v);
      r.wru = v[0];
      takeBits(3, v);
      r.pi = v[2:0];
      rows.push_back(r);
   endtask

   // Level write goes into bits 17..15 and 14..12
   task automatic applyRow(input rowT r);
      csrWr      = '0;
      csrWr.wr   = (r.op == 2'd1) || (r.op == 2'd3);
      csrWr.init = (r.op == 2'd2);
      if (csrWr.wr)
      begin
         csrWr.data[17:15] = r.pih;
         csrWr.data[14:12] = r.pil;
         csrWr.data[6]     = (r.op == 2'd3);
      end
      dev1Req    = r.dev1;
      dev2Req    = r.dev2;
      wruRead    = r.wru;
      busPi      = r.pi;
      tableInta  = r.expInta;
      tableCheck = r.hasExp;
   endtask

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////

   task automatic buildTable();
      // Levels still 0 so no line and no grant
      addRow(0, 0, 0, 4'b1010, 4'b0000, 1, 0, intaNone);
      addRow(0, 0, 0, 4'b1111, 4'b0000, 1, 3, intaNone);
      addRow(1, 5, 2, 4'b0000, 4'b0000, 0, 0, intaNone);
      addRow(0, 0, 0, 4'b0100, 4'b0000, 1, 5, intaBr6);
      addRow(0, 0, 0, 4'b1000, 4'b0100, 1, 5, intaBr7);
      addRow(0, 0, 0, 4'b0011, 4'b0000, 1, 5, intaNone);
      // Back-to-back strobes at the low level
      addRow(0, 0, 0, 4'b0011, 4'b0000, 1, 2, intaBr5);
      addRow(0, 0, 0, 4'b0000, 4'b0001, 1, 2, intaBr4);
      addRow(0, 0, 0, 4'b1001, 4'b0000, 1, 2, intaBr4);
      addRow(0, 0, 0, 4'b1001, 4'b0000, 1, 4, intaNone);
      addRow(0, 0, 0, 4'b1001, 4'b0000, 0, 5, intaNone);
      // Equal levels favor the high group
      addRow(1, 4, 4, 4'b0000, 4'b0000, 0, 0, intaNone);
      addRow(0, 0, 0, 4'b0101, 4'b0000, 1, 4, intaBr6);
      addRow(0, 0, 0, 4'b0011, 4'b0000, 1, 4, intaNone);
      addRow(2, 0, 0, 4'b1111, 4'b0000, 0, 0, intaNone);
      addRow(0, 0, 0, 4'b1111, 4'b0000, 1, 4, intaNone);
      addRow(1, 7, 1, 4'b0000, 4'b1111, 0, 0, intaNone);
      addRow(0, 0, 0, 4'b0000, 4'b0010, 1, 1, intaBr5);
      // Init bit inside a level write
      addRow(3, 6, 3, 4'b0000, 4'b0000, 0, 0, intaNone);
      addRow(0, 0, 0, 4'b1100, 4'b0000, 1, 6, intaNone);
      // Grant still sees the old levels
      addRow(1, 0, 6, 4'b0001, 4'b0000, 1, 6, intaNone);
      addRow(0, 0, 0, 4'b0001, 4'b0000, 1, 6, intaBr4);
      addRow(0, 0, 0, 4'b1001, 4'b0000, 1, 0, intaNone);
      for (int i = 0; i < 40; i++)
         addRandom();
   endtask

   initial
   begin
      lfsr     = 32'h9bb1;
      timedOut = 1'b0;
      rst      = 1'b1;
      applyRow('0);
      buildTable();
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      waitCnt = 0;
      while (checkCount == 0 && waitCnt < 20)
      begin
         @(posedge clk);
         waitCnt++;
      end
      if (checkCount == 0)
      begin
         $display("Timeout: the checker never saw reset released");
         timedOut = 1'b1;
      end
      if (!timedOut)
      begin
         foreach (rows[i])
         begin
            @(posedge clk);
            #1;
            applyRow(rows[i]);
         end
         @(posedge clk);
         #1;
         applyRow('0);
         // Last row's grant shows up one edge later
         target  = checkCount + 1;
         waitCnt = 0;
         while (checkCount < target && waitCnt < 20)
         begin
            @(posedge clk);
            waitCnt++;
         end
         if (checkCount < target)
         begin
            $display("Timeout: the checker stopped before the end of the table");
            timedOut = 1'b1;
         end
      end
      $display("Checked %0d cycles, %0d errors", checkCount, errCount);
      if (!timedOut && errCount == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* list.f */
verilog/ubaPkg.sv
verilog/ubaCsrPkg.sv
verilog/ubaStatus.sv
verilog/ubaIntr.sv
verilog/ubaWru.sv
verilog/ubaTop.sv
bench/ubaChecker.sv
bench/ubaBench.sv

/* Makefile */
SIM      = verilator
TOP      = ubaBench
FILELIST = list.f
FLAGS    = --binary --timing -Wno-fatal -j 0
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASSMSG)' $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
